/* execPkg.sv */
`default_nettype none

package execPkg;

  // ======================================================================
  // Widths and sizes
  // ======================================================================

  localparam int dataW    = 32;
  localparam int regCount = 32;
  localparam int regSelW  = 5;
  localparam int instrW   = 32;
  localparam int immW     = 16;

  // ======================================================================
  // Instruction field positions
  // ======================================================================

  localparam int opcodeHi = 31;
  localparam int opcodeLo = 26;
  localparam int rdHi     = 25;
  localparam int rdLo     = 21;
  localparam int rs1Hi    = 20;
  localparam int rs1Lo    = 16;
  localparam int rs2Hi    = 15;
  localparam int rs2Lo    = 11;
  localparam int immHi    = 15;
  localparam int immLo    = 0;

  // Legal codes run 0 to 9, anything above is illegal
  typedef enum logic [5:0] {
    opAdd  = 6'd0,
    opSub  = 6'd1,
    opAnd  = 6'd2,
    opOr   = 6'd3,
    opXor  = 6'd4,
    opSlt  = 6'd5,
    opSll  = 6'd6,
    opSrl  = 6'd7,
    opAddi = 6'd8,
    opLui  = 6'd9
  } opcodeT;

  typedef struct packed {
    opcodeT             op;
    logic [regSelW-1:0] rd;
    logic [regSelW-1:0] rs1;
    logic [regSelW-1:0] rs2;
    logic [dataW-1:0]   imm;
    logic               useImm;
    logic               illegal;
  } decodedT;

  typedef struct packed {
    logic [regSelW-1:0] rd;
    logic [dataW-1:0]   data;
    logic               err;
  } resultT;

endpackage

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [execPkg::regSelW-1:0] rdSel1,
  input  logic [execPkg::regSelW-1:0] rdSel2,
  input  logic [execPkg::regSelW-1:0] wrSel,
  input  logic [execPkg::dataW-1:0]   wrData,
  input  logic                        wrEn,
  output logic [execPkg::dataW-1:0]   rdData1,
  output logic [execPkg::dataW-1:0]   rdData2
);

  import execPkg::*;

  // ======================================================================
  // Register array
  // ======================================================================

  // Register 0 is a normal storage location
  logic [dataW-1:0] regs [regCount];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrSel] <= wrData;
    end
  end

  // ======================================================================
  // Read ports
  // ======================================================================

  // Straight index, every select maps to its own entry
  always_comb begin
    rdData1 = regs[rdSel1];
    rdData2 = regs[rdSel2];
  end

endmodule

`default_nettype wire

/* instrDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
  input  logic [execPkg::instrW-1:0] instr,
  output execPkg::decodedT           dec
);

  import execPkg::*;

  logic [opcodeHi-opcodeLo:0] rawOp;
  logic [immW-1:0]            imm16;
  logic                       badOp;

  // ======================================================================
  // Field extraction
  // ======================================================================

  assign rawOp = instr[opcodeHi:opcodeLo];
  assign imm16 = instr[immHi:immLo];

  // Codes above the last enum entry have no meaning
  assign badOp = (rawOp > opLui);

  // ======================================================================
  // Decoded word
  // ======================================================================

  always_comb begin
    dec.rd      = instr[rdHi:rdLo];
    dec.rs1     = instr[rs1Hi:rs1Lo];
    dec.rs2     = instr[rs2Hi:rs2Lo];
    dec.illegal = badOp;

    // Keep the enum inside its range on a bad code
    if (badOp) begin
      dec.op = opAdd;
    end else begin
      dec.op = opcodeT'(rawOp);
    end

    case (dec.op)
      opAddi: begin
        dec.imm    = {{(dataW-immW){imm16[immW-1]}}, imm16};
        dec.useImm = 1'b1;
      end
      opLui: begin
        dec.imm    = {imm16, {(dataW-immW){1'b0}}};
        dec.useImm = 1'b1;
      end
      default: begin
        dec.imm    = '0;
        dec.useImm = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
  input  execPkg::opcodeT           op,
  input  logic [execPkg::dataW-1:0] a,
  input  logic [execPkg::dataW-1:0] b,
  output logic [execPkg::dataW-1:0] y
);

  import execPkg::*;

  logic [4:0]       shamt;
  logic [dataW-1:0] sum;
  logic [dataW-1:0] diff;
  logic             lessThan;

  // ======================================================================
  // Shared datapath pieces
  // ======================================================================

  assign shamt = b[4:0];
  assign sum   = a + b;
  assign diff  = a - b;

  // Signed compare for SLT
  assign lessThan = ($signed(a) < $signed(b));

  // ======================================================================
  // Result select
  // ======================================================================

  always_comb begin
    case (op)
      // LUI relies on rs1 holding zero
      opAdd, opAddi, opLui: begin
        y = sum;
      end
      opSub: begin
        y = diff;
      end
      opAnd: begin
        y = a & b;
      end
      opOr: begin
        y = a | b;
      end
      opXor: begin
        y = a ^ b;
      end
      opSlt: begin
        y = {{(dataW-1){1'b0}}, lessThan};
      end
      opSll: begin
        y = a << shamt;
      end
      opSrl: begin
        y = a >> shamt;
      end
      default: begin
        y = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* execCore.sv */
`timescale 1ns/1ps
`default_nettype none

module execCore (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       instrValid,
  input  logic [execPkg::instrW-1:0] instr,
  output logic                       resultValid,
  output execPkg::resultT            result
);

  import execPkg::*;

  decodedT          dec;
  logic [dataW-1:0] rdData1;
  logic [dataW-1:0] rdData2;
  logic [dataW-1:0] aluB;
  logic [dataW-1:0] aluY;
  logic             wrEn;

  // ======================================================================
  // Decode and operand read
  // ======================================================================

  instrDecode uDecode (
    .instr (instr),
    .dec   (dec)
  );

  // Written at the issue edge, so the next instruction sees the new value
  assign wrEn = instrValid && !dec.illegal;

  regFile uRegFile (
    .clk     (clk),
    .rst     (rst),
    .rdSel1  (dec.rs1),
    .rdSel2  (dec.rs2),
    .wrSel   (dec.rd),
    .wrData  (aluY),
    .wrEn    (wrEn),
    .rdData1 (rdData1),
    .rdData2 (rdData2)
  );

  // ======================================================================
  // Execute
  // ======================================================================

  assign aluB = dec.useImm ? dec.imm : rdData2;

  aluUnit uAlu (
    .op (dec.op),
    .a  (rdData1),
    .b  (aluB),
    .y  (aluY)
  );

  // ======================================================================
  // Result stage
  // ======================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      resultValid <= 1'b0;
      result      <= '0;
    end else begin
      resultValid <= instrValid;
      if (instrValid) begin
        result.rd   <= dec.rd;
        result.err  <= dec.illegal;
        // Bad opcode reports zero data
        result.data <= dec.illegal ? '0 : aluY;
      end
    end
  end

endmodule

`default_nettype wire

/* execCore_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module execCoreSva (
  input logic            clk,
  input logic            rst,
  input logic            instrValid,
  input logic            wrEn,
  input logic            resultValid,
  input execPkg::resultT result
);

  import execPkg::*;

  // Quiet output once reset has been seen
  resetQuiet: assert property (@(posedge clk) rst |=> (!resultValid && result == '0))
    else $error("resultValid or result not cleared by reset");

  // One cycle from issue to result strobe
  strobeFollows: assert property (@(posedge clk) disable iff (rst)
    instrValid |=> resultValid)
    else $error("resultValid missing one cycle after issue");

  strobeOnlyAfterIssue: assert property (@(posedge clk) disable iff (rst)
    !instrValid |=> !resultValid)
    else $error("resultValid without a preceding issue");

  // Flagged result means the register file was left alone
  errNoWrite: assert property (@(posedge clk) disable iff (rst)
    (resultValid && result.err) |-> !$past(wrEn))
    else $error("register write on an illegal opcode");

endmodule

bind execCore execCoreSva uSva (
  .clk         (clk),
  .rst         (rst),
  .instrValid  (instrValid),
  .wrEn        (wrEn),
  .resultValid (resultValid),
  .result      (result)
);

`default_nettype wire

/* execChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module execChecker (
  input  logic            clk,
  input  logic            rst,
  input  logic            instrValid,
  input  execPkg::resultT expResult,
  input  logic            resultValid,
  input  execPkg::resultT result,
  output int              checkedCount,
  output int              errorCount
);

  import execPkg::*;

  // Expectations waiting for their result strobe
  resultT pending[$];
  resultT exp;

  always @(posedge clk) begin
    if (rst) begin
      pending.delete();
      checkedCount = 0;
      errorCount   = 0;
    end else begin
      // Retire before accepting a new issue on the same edge
      if (resultValid) begin
        if (pending.size() == 0) begin
          errorCount++;
          $display("unexpected result at %0t with no instruction pending", $time);
        end else begin
          exp = pending.pop_front();
          if (result !== exp) begin
            errorCount++;
            $display("mismatch at %0t: test %0d rd/data/err got %0d/%h/%b expected %0d/%h/%b",
                     $time, checkedCount, result.rd, result.data, result.err,
                     exp.rd, exp.data, exp.err);
          end else begin
            $display("test %0d ok: rd=%0d data=%h err=%b",
                     checkedCount, result.rd, result.data, result.err);
          end
          checkedCount++;
        end
      end
      if (instrValid) begin
        pending.push_back(expResult);
      end
    end
  end

endmodule

`default_nettype wire

/* tb_execCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_execCore;

  import execPkg::*;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] data;
    logic        err;
    logic        noGap;
  } stepT;

  logic        clk;
  logic        rst;
  logic        instrValid;
  logic [31:0] instr;
  logic        resultValid;
  resultT      result;
  resultT      expResult;
  int          checkedCount;
  int          errorCount;
  int          seed;
  int          gap;
  int          waitCnt;
  int          timeouts;
  stepT        steps[$];
  stepT        cur;

  execCore dut (
    .clk         (clk),
    .rst         (rst),
    .instrValid  (instrValid),
    .instr       (instr),
    .resultValid (resultValid),
    .result      (result)
  );

  execChecker uChecker (
    .clk          (clk),
    .rst          (rst),
    .instrValid   (instrValid),
    .expResult    (expResult),
    .resultValid  (resultValid),
    .result       (result),
    .checkedCount (checkedCount),
    .errorCount   (errorCount)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] encodeReg(input logic [5:0] op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [4:0] rs2);
    return {op, rd, rs1, rs2, 11'd0};
  endfunction

  function automatic logic [31:0] encodeImm(input logic [5:0] op, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [15:0] imm);
    return {op, rd, rs1, imm};
  endfunction

  task automatic addStep(input logic [31:0] word, input logic [31:0] data,
                         input logic err, input logic noGap);
    steps.push_back('{instr: word, data: data, err: err, noGap: noGap});
  endtask

  // ====================================================================
  // Stimulus table
  // ====================================================================

  task automatic buildTable();
    addStep(encodeReg(opAdd, 3, 1, 2), 32'h0000_0000, 1'b0, 1'b0);
    addStep(encodeImm(opLui, 1, 0, 16'h1234), 32'h1234_0000, 1'b0, 1'b0);
    addStep(encodeImm(opAddi, 1, 1, 16'h5678), 32'h1234_5678, 1'b0, 1'b1);
    addStep(encodeImm(opAddi, 2, 0, 16'hffff), 32'hffff_ffff, 1'b0, 1'b0);
    addStep(encodeImm(opAddi, 4, 0, 16'h8000), 32'hffff_8000, 1'b0, 1'b0);
    addStep(encodeReg(opAdd, 5, 1, 2), 32'h1234_5677, 1'b0, 1'b0);
    addStep(encodeReg(opSub, 6, 0, 1), 32'hedcb_a988, 1'b0, 1'b0);
    addStep(encodeReg(opAnd, 7, 1, 4), 32'h1234_0000, 1'b0, 1'b0);
    addStep(encodeReg(opOr, 8, 1, 4), 32'hffff_d678, 1'b0, 1'b0);
    addStep(encodeReg(opXor, 9, 1, 2), 32'hedcb_a987, 1'b0, 1'b0);
    addStep(encodeReg(opSlt, 10, 4, 2), 32'h0000_0001, 1'b0, 1'b0);
    addStep(encodeReg(opSlt, 11, 2, 4), 32'h0000_0000, 1'b0, 1'b0);
    addStep(encodeImm(opAddi, 12, 0, 16'd31), 32'h0000_001f, 1'b0, 1'b0);
    addStep(encodeReg(opSll, 13, 2, 12), 32'h8000_0000, 1'b0, 1'b0);
    addStep(encodeReg(opSrl, 14, 2, 12), 32'h0000_0001, 1'b0, 1'b0);
    addStep(encodeReg(opSll, 15, 1, 0), 32'h1234_5678, 1'b0, 1'b0);
    addStep(encodeReg(opSrl, 16, 4, 0), 32'hffff_8000, 1'b0, 1'b0);
    // Back to back on the same register
    addStep(encodeImm(opAddi, 17, 0, 16'd5), 32'h0000_0005, 1'b0, 1'b0);
    addStep(encodeReg(opAdd, 17, 17, 17), 32'h0000_000a, 1'b0, 1'b1);
    addStep(encodeImm(opAddi, 30, 0, 16'h0030), 32'h0000_0030, 1'b0, 1'b0);
    addStep(encodeImm(opAddi, 31, 0, 16'h0031), 32'h0000_0031, 1'b0, 1'b1);
    addStep(encodeReg(opAdd, 18, 30, 0), 32'h0000_0030, 1'b0, 1'b0);
    addStep(encodeReg(opAdd, 19, 31, 0), 32'h0000_0031, 1'b0, 1'b0);
    // Illegal code aimed at r1, then r1 read back
    addStep(encodeImm(6'h3f, 1, 0, 16'h0000), 32'h0000_0000, 1'b1, 1'b0);
    addStep(encodeReg(opAdd, 20, 1, 0), 32'h1234_5678, 1'b0, 1'b0);
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================

  initial begin
    seed       = 32'hef73_069b;
    rst        = 1'b1;
    instrValid = 1'b0;
    instr      = '0;
    expResult  = '0;
    timeouts   = 0;
    buildTable();
    repeat (2) @(negedge clk);
    rst = 1'b0;

    foreach (steps[i]) begin
      cur = steps[i];
      if (!cur.noGap) begin
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) @(negedge clk);
      end
      instr      = cur.instr;
      expResult  = '{rd: cur.instr[rdHi:rdLo], data: cur.data, err: cur.err};
      instrValid = 1'b1;
      @(negedge clk);
      instrValid = 1'b0;
      waitCnt    = 0;
      while (!resultValid && waitCnt < 20) begin
        @(negedge clk);
        waitCnt++;
      end
      if (!resultValid) begin
        timeouts++;
        $display("timeout: no result strobe for test %0d within 20 cycles", i);
      end
    end

    // Let the checker retire the last result
    repeat (3) @(negedge clk);
    $display("tests %0d, checked %0d, errors %0d, timeouts %0d",
             steps.size(), checkedCount, errorCount, timeouts);
    if (timeouts == 0 && errorCount == 0 && checkedCount == steps.size()) begin
      $display(">>> PASS");
    end else begin
      if (checkedCount != steps.size()) begin
        $display("only %0d of %0d results reached the checker", checkedCount, steps.size());
      end
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* execCore.f */
execPkg.sv
regFile.sv
instrDecode.sv
aluUnit.sv
execCore.sv
execCore_sva.sv
execChecker.sv
tb_execCore.sv

/* Makefile */
TOP = tb_execCore

.PHONY: lint sim clean

lint:
	verilator --lint-only execPkg.sv regFile.sv instrDecode.sv aluUnit.sv execCore.sv \
		--top-module execCore
	verilator --lint-only --timing --assert -f execCore.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f execCore.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q '>>> FAIL' sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q '>>> PASS' sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
